// File: files.f
source/rv_arch_pkg.sv
source/hazard_pkg.sv
source/hazard_detect.sv
source/forward_mux.sv
source/stall_fsm.sv
source/mem_wait_timer.sv
source/hazard_unit.sv
test/hazard_unit_properties.sv
test/hazard_unit_tb.sv

// File: Makefile
TOP = hazard_unit_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f files.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: test/hazard_unit_tb.sv
module hazard_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rv_arch_pkg::*;
    import hazard_pkg::*;

    localparam int MEM_TIMEOUT     = 6;
    localparam int RESET_CYCLES    = 8;
    localparam int RANDOM_CYCLES   = 400;
    localparam int DIRECTED_CYCLES = 60;
    localparam int CYCLE_LIMIT     = RESET_CYCLES + RANDOM_CYCLES + DIRECTED_CYCLES + 100;

    typedef struct packed {
        fwd_sel_t sel;
        xlen_t    val;
    } operand_t;

    logic         clk;
    logic         rst_n;
    id_req_t      id_req;
    stage_dst_t   ex_dst;
    stage_dst_t   mem_dst;
    stage_dst_t   wb_dst;
    logic         mem_start;
    logic         mem_ready;
    hazard_ctrl_t ctrl;
    fwd_sel_t     op1_sel;
    fwd_sel_t     op2_sel;
    xlen_t        op1;
    xlen_t        op2;
    stall_state_t state;

    integer       seed = 32'hc630;
    int           cycles = 0;
    stall_state_t ref_state;
    logic         ref_fault;
    int           ref_wait;

    hazard_unit #(
        .MEM_TIMEOUT (MEM_TIMEOUT)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .id_req    (id_req),
        .ex_dst    (ex_dst),
        .mem_dst   (mem_dst),
        .wb_dst    (wb_dst),
        .mem_start (mem_start),
        .mem_ready (mem_ready),
        .ctrl      (ctrl),
        .op1_sel   (op1_sel),
        .op2_sel   (op2_sel),
        .op1       (op1),
        .op2       (op2),
        .state     (state)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at time %0d ns", $time);
    endtask

    task automatic check(input string name, input xlen_t actual, input xlen_t expected);
        if (actual !== expected) begin
            stop_run($sformatf("CHECK FAILED at time %0d ns: %s is %0h, expected %0h",
                               $time, name, actual, expected));
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_run("timeout: the tests did not finish within the cycle limit");
        end
    end

    // ####################################################################
    // reference model.
    // ####################################################################

    function automatic logic writes(reg_addr_t rs, logic used, stage_dst_t dst);
        if (!used || rs == '0) begin
            return 1'b0; // x0 and unused sources never match.
        end
        return dst.wr_en && (dst.rd == rs);
    endfunction

    function automatic operand_t ref_operand(reg_addr_t rs, logic used, xlen_t rf_val);
        operand_t o;
        o.sel = FWD_RF;
        o.val = rf_val;
        if (writes(rs, used, ex_dst) && !ex_dst.is_load) begin
            o.sel = FWD_EX;
            o.val = ex_dst.data;
        end else if (writes(rs, used, mem_dst)) begin
            o.sel = FWD_MEM;
            o.val = mem_dst.data;
        end else if (writes(rs, used, wb_dst)) begin
            o.sel = FWD_WB;
            o.val = wb_dst.data;
        end
        return o;
    endfunction

    function automatic logic ref_load_use();
        return ex_dst.is_load && (writes(id_req.rs1, id_req.rs1_used, ex_dst) ||
                                  writes(id_req.rs2, id_req.rs2_used, ex_dst));
    endfunction

    // compare at the falling edge and step the model for the next cycle.
    always @(negedge clk) begin
        operand_t     exp1;
        operand_t     exp2;
        hazard_ctrl_t exp_ctrl;
        stall_state_t nxt;
        if (!rst_n) begin
            ref_state = ST_RUN;
            ref_fault = 1'b0;
            ref_wait  = 0;
        end else begin
            exp1 = ref_operand(id_req.rs1, id_req.rs1_used, id_req.rf_rs1);
            exp2 = ref_operand(id_req.rs2, id_req.rs2_used, id_req.rf_rs2);
            exp_ctrl = '0;
            exp_ctrl.mem_fault = ref_fault;
            ref_fault = 1'b0;
            nxt = ref_state;
            case (ref_state)
                ST_RUN: begin
                    if (mem_start) begin
                        nxt = ST_MEM_WAIT;
                        ref_wait = 0;
                    end else if (ref_load_use()) begin
                        exp_ctrl.stall_id  = 1'b1;
                        exp_ctrl.bubble_ex = 1'b1;
                        nxt = ST_LOAD_BUBBLE;
                    end
                end
                ST_LOAD_BUBBLE: nxt = ST_RUN;
                default: begin
                    exp_ctrl.freeze_all = 1'b1;
                    ref_wait = ref_wait + 1; // number of this wait cycle.
                    if (mem_ready || ref_wait == MEM_TIMEOUT) begin
                        nxt = ST_RUN;
                    end
                    ref_fault = !mem_ready && (ref_wait == MEM_TIMEOUT);
                end
            endcase
            check("state", xlen_t'(state), xlen_t'(ref_state));
            check("ctrl.stall_id", xlen_t'(ctrl.stall_id), xlen_t'(exp_ctrl.stall_id));
            check("ctrl.bubble_ex", xlen_t'(ctrl.bubble_ex), xlen_t'(exp_ctrl.bubble_ex));
            check("ctrl.freeze_all", xlen_t'(ctrl.freeze_all), xlen_t'(exp_ctrl.freeze_all));
            check("ctrl.mem_fault", xlen_t'(ctrl.mem_fault), xlen_t'(exp_ctrl.mem_fault));
            check("op1_sel", xlen_t'(op1_sel), xlen_t'(exp1.sel));
            check("op2_sel", xlen_t'(op2_sel), xlen_t'(exp2.sel));
            check("op1", op1, exp1.val);
            check("op2", op2, exp2.val);
            ref_state = nxt;
        end
    end

    // ####################################################################
    // stimulus.
    // ####################################################################

    function automatic reg_addr_t rand_reg();
        logic [31:0] r;
        r = $random(seed);
        return reg_addr_t'(r[1:0]); // only x0 to x3 so that matches are common.
    endfunction

    function automatic stage_dst_t rand_dst();
        stage_dst_t  d;
        logic [31:0] r;
        r = $random(seed);
        d.rd      = rand_reg();
        d.wr_en   = r[4] | r[5];
        d.is_load = r[6] & r[7];
        d.data    = {$random(seed), $random(seed)};
        return d;
    endfunction

    function automatic id_req_t rand_req();
        id_req_t     q;
        logic [31:0] r;
        r = $random(seed);
        q.rs1      = rand_reg();
        q.rs2      = rand_reg();
        q.rs1_used = r[0] | r[1];
        q.rs2_used = r[2] | r[3];
        q.rf_rs1   = {$random(seed), $random(seed)};
        q.rf_rs2   = {$random(seed), $random(seed)};
        return q;
    endfunction

    function automatic id_req_t reads_x9();
        id_req_t q;
        q = '0;
        q.rs1      = 5'd3;
        q.rs1_used = 1'b1;
        q.rs2      = 5'd9;
        q.rs2_used = 1'b1;
        q.rf_rs1   = 64'h0123_4567_89ab_cdef;
        q.rf_rs2   = 64'hfeed_face_0000_0009;
        return q;
    endfunction

    function automatic stage_dst_t load_to_x9();
        stage_dst_t d;
        d.rd      = 5'd9;
        d.wr_en   = 1'b1;
        d.is_load = 1'b1;
        d.data    = 64'h0bad_cafe_1234_5678;
        return d;
    endfunction

    task automatic run_random(input int n);
        repeat (n) begin
            @(posedge clk);
            id_req  <= rand_req();
            ex_dst  <= rand_dst();
            mem_dst <= rand_dst();
            wb_dst  <= rand_dst();
        end
    endtask

    task automatic clear_inputs();
        @(posedge clk);
        id_req  <= '0;
        ex_dst  <= '0;
        mem_dst <= '0;
        wb_dst  <= '0;
        @(posedge clk); // lets a pending bubble drain.
    endtask

    task automatic run_load_use();
        stage_dst_t ld;
        ld = load_to_x9();
        @(posedge clk);
        id_req <= reads_x9();
        ex_dst <= ld;
        @(negedge clk);
        check("stall_id on load-use", xlen_t'(ctrl.stall_id), 64'd1);
        check("bubble_ex on load-use", xlen_t'(ctrl.bubble_ex), 64'd1);
        @(negedge clk);
        check("state in bubble", xlen_t'(state), xlen_t'(ST_LOAD_BUBBLE));
        check("stall_id in bubble", xlen_t'(ctrl.stall_id), 64'd0);
        check("bubble_ex in bubble", xlen_t'(ctrl.bubble_ex), 64'd0);
        @(posedge clk);
        ex_dst  <= '0;
        mem_dst <= ld; // the load moved on to MEM.
        @(negedge clk);
        check("op2_sel after bubble", xlen_t'(op2_sel), xlen_t'(FWD_MEM));
        check("op2 after bubble", op2, ld.data);
    endtask

    // ready_at 0 means memory never answers.
    task automatic run_mem_wait(input int ready_at, input int exp_freeze,
                                input id_req_t req, input stage_dst_t ex);
        int waited;
        waited = 0;
        @(posedge clk);
        mem_start <= 1'b1;
        id_req    <= req;
        ex_dst    <= ex;
        @(negedge clk);
        check("stall_id at mem_start", xlen_t'(ctrl.stall_id), 64'd0);
        check("bubble_ex at mem_start", xlen_t'(ctrl.bubble_ex), 64'd0);
        @(posedge clk);
        mem_start <= 1'b0;
        mem_ready <= (ready_at == 1);
        @(negedge clk);
        while (ctrl.freeze_all) begin
            waited++;
            if (waited > MEM_TIMEOUT) begin
                stop_run("freeze_all stayed high past the memory wait limit");
            end
            @(posedge clk);
            mem_ready <= (ready_at == waited + 1);
            @(negedge clk);
        end
        check("freeze_all cycles", xlen_t'(waited), xlen_t'(exp_freeze));
        check("mem_fault after wait", xlen_t'(ctrl.mem_fault), xlen_t'(ready_at == 0));
        check("state after wait", xlen_t'(state), xlen_t'(ST_RUN));
    endtask

    initial begin
        rst_n     = 1'b0;
        id_req    = '0;
        ex_dst    = '0;
        mem_dst   = '0;
        wb_dst    = '0;
        mem_start = 1'b0;
        mem_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check("state after reset", xlen_t'(state), xlen_t'(ST_RUN));
        check("ctrl after reset", xlen_t'(ctrl), '0);

        run_random(RANDOM_CYCLES);
        clear_inputs();
        run_load_use();
        clear_inputs();

        for (int k = 1; k < MEM_TIMEOUT; k++) begin
            run_mem_wait(k, k, '0, '0);
        end
        run_mem_wait(0, MEM_TIMEOUT, '0, '0);
        run_mem_wait(3, 3, reads_x9(), load_to_x9()); // wait wins over load-use.
        clear_inputs();

        repeat (3) @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: test/hazard_unit_properties.sv
module hazard_unit_properties (
    input logic                     clk,
    input logic                     rst_n,
    input hazard_pkg::hazard_ctrl_t ctrl,
    input hazard_pkg::stall_state_t state
);

    timeunit 1ns;
    timeprecision 100ps;

    import hazard_pkg::*;

    // ####################################################################
    // stall machine rules.
    // ####################################################################

    bubble_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == ST_LOAD_BUBBLE) |=> (state != ST_LOAD_BUBBLE)
    ) else $error("load bubble state lasted more than one cycle");

    freeze_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n)
        ctrl.freeze_all == (state == ST_MEM_WAIT)
    ) else $error("freeze_all does not follow the memory wait state");

    fault_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        ctrl.mem_fault |=> !ctrl.mem_fault
    ) else $error("mem_fault stayed high for more than one cycle");

    stall_has_bubble: assert property (
        @(posedge clk) disable iff (!rst_n)
        ctrl.stall_id |-> ctrl.bubble_ex
    ) else $error("stall_id raised without bubble_ex");

endmodule

bind hazard_unit hazard_unit_properties u_hazard_unit_properties (
    .clk   (clk),
    .rst_n (rst_n),
    .ctrl  (ctrl),
    .state (state)
);

// File: source/hazard_unit.sv
module hazard_unit #(
    parameter int MEM_TIMEOUT = 16
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  hazard_pkg::id_req_t      id_req,
    input  hazard_pkg::stage_dst_t   ex_dst,
    input  hazard_pkg::stage_dst_t   mem_dst,
    input  hazard_pkg::stage_dst_t   wb_dst,
    input  logic                     mem_start,
    input  logic                     mem_ready,
    output hazard_pkg::hazard_ctrl_t ctrl,
    output hazard_pkg::fwd_sel_t     op1_sel,
    output hazard_pkg::fwd_sel_t     op2_sel,
    output rv_arch_pkg::xlen_t       op1,
    output rv_arch_pkg::xlen_t       op2,
    output hazard_pkg::stall_state_t state
);

    logic load_use;
    logic in_bubble;
    logic timer_start;
    logic timer_clear;
    logic expired;

    // ####################################################################
    // datapath side.
    // ####################################################################

    hazard_detect u_hazard_detect (
        .clk       (clk),
        .rst_n     (rst_n),
        .id_req    (id_req),
        .ex_dst    (ex_dst),
        .in_bubble (in_bubble),
        .load_use  (load_use)
    );

    forward_mux u_forward_mux (
        .id_req  (id_req),
        .ex_dst  (ex_dst),
        .mem_dst (mem_dst),
        .wb_dst  (wb_dst),
        .op1_sel (op1_sel),
        .op2_sel (op2_sel),
        .op1     (op1),
        .op2     (op2)
    );

    // ####################################################################
    // stall control.
    // ####################################################################

    stall_fsm u_stall_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_use    (load_use),
        .mem_start   (mem_start),
        .mem_ready   (mem_ready),
        .expired     (expired),
        .in_bubble   (in_bubble),
        .timer_start (timer_start),
        .timer_clear (timer_clear),
        .ctrl        (ctrl),
        .state       (state)
    );

    mem_wait_timer #(
        .MEM_TIMEOUT (MEM_TIMEOUT)
    ) u_mem_wait_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .timer_start (timer_start),
        .timer_clear (timer_clear),
        .expired     (expired)
    );

endmodule

// File: source/mem_wait_timer.sv
module mem_wait_timer #(
    parameter int MEM_TIMEOUT = 16
) (
    input  logic clk,
    input  logic rst_n,
    input  logic timer_start,
    input  logic timer_clear,
    output logic expired
);

    localparam int CNT_W = $clog2(MEM_TIMEOUT + 1);

    logic [CNT_W-1:0] count;
    logic             busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            busy  <= 1'b0;
        end else if (timer_clear) begin
            count <= '0;
            busy  <= 1'b0;
        end else if (timer_start) begin
            count <= CNT_W'(MEM_TIMEOUT); // first wait cycle sees the full count.
            busy  <= 1'b1;
        end else if (busy && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    // count hits zero on this edge, the last allowed wait cycle.
    assign expired = busy && (count == CNT_W'(1));

endmodule

// File: source/stall_fsm.sv
module stall_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load_use,
    input  logic                     mem_start,
    input  logic                     mem_ready,
    input  logic                     expired,
    output logic                     in_bubble,
    output logic                     timer_start,
    output logic                     timer_clear,
    output hazard_pkg::hazard_ctrl_t ctrl,
    output hazard_pkg::stall_state_t state
);

    import hazard_pkg::*;

    stall_state_t state_nxt;
    logic         fault_set;
    logic         fault_q;

    // ####################################################################
    // state and fault flag.
    // ####################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_RUN;
            fault_q <= 1'b0;
        end else begin
            state   <= state_nxt;
            fault_q <= fault_set; // one cycle, on the way back to run.
        end
    end

    // ####################################################################
    // next state and controls.
    // ####################################################################

    always_comb begin
        state_nxt      = state;
        ctrl           = '0;
        ctrl.mem_fault = fault_q;
        timer_start    = 1'b0;
        timer_clear    = 1'b0;
        fault_set      = 1'b0;

        case (state)
            ST_RUN: begin
                if (mem_start) begin // memory wait beats load-use.
                    state_nxt   = ST_MEM_WAIT;
                    timer_start = 1'b1;
                end else if (load_use) begin
                    ctrl.stall_id  = 1'b1;
                    ctrl.bubble_ex = 1'b1;
                    state_nxt      = ST_LOAD_BUBBLE;
                end
            end
            ST_LOAD_BUBBLE: begin
                state_nxt = ST_RUN; // single nop only.
            end
            ST_MEM_WAIT: begin
                ctrl.freeze_all = 1'b1;
                if (mem_ready) begin
                    state_nxt   = ST_RUN;
                    timer_clear = 1'b1;
                end else if (expired) begin
                    state_nxt   = ST_RUN;
                    timer_clear = 1'b1;
                    fault_set   = 1'b1;
                end
            end
            default: begin
                state_nxt = ST_RUN;
            end
        endcase
    end

    assign in_bubble = (state == ST_LOAD_BUBBLE);

endmodule

// File: source/forward_mux.sv
module forward_mux (
    input  hazard_pkg::id_req_t    id_req,
    input  hazard_pkg::stage_dst_t ex_dst,
    input  hazard_pkg::stage_dst_t mem_dst,
    input  hazard_pkg::stage_dst_t wb_dst,
    output hazard_pkg::fwd_sel_t   op1_sel,
    output hazard_pkg::fwd_sel_t   op2_sel,
    output rv_arch_pkg::xlen_t     op1,
    output rv_arch_pkg::xlen_t     op2
);

    import rv_arch_pkg::*;
    import hazard_pkg::*;

    // youngest writer wins; a load in EX has no data yet.
    function automatic fwd_sel_t pick_src(
        reg_addr_t  rs,
        logic       used,
        stage_dst_t ex,
        stage_dst_t mem,
        stage_dst_t wb
    );
        fwd_sel_t sel;
        sel = FWD_RF;
        if (src_hits(rs, used, ex) && !ex.is_load) begin
            sel = FWD_EX;
        end else if (src_hits(rs, used, mem)) begin
            sel = FWD_MEM;
        end else if (src_hits(rs, used, wb)) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    function automatic xlen_t mux_src(fwd_sel_t sel, xlen_t rf_val);
        xlen_t val;
        case (sel)
            FWD_EX:  val = ex_dst.data;
            FWD_MEM: val = mem_dst.data;
            FWD_WB:  val = wb_dst.data;
            default: val = rf_val;
        endcase
        return val;
    endfunction

    // ####################################################################
    // operand paths.
    // ####################################################################

    always_comb begin
        op1_sel = pick_src(id_req.rs1, id_req.rs1_used, ex_dst, mem_dst, wb_dst);
        op2_sel = pick_src(id_req.rs2, id_req.rs2_used, ex_dst, mem_dst, wb_dst);
    end

    always_comb begin
        op1 = mux_src(op1_sel, id_req.rf_rs1);
        op2 = mux_src(op2_sel, id_req.rf_rs2);
    end

endmodule

// File: source/hazard_detect.sv
module hazard_detect (
    input  logic                   clk,
    input  logic                   rst_n,
    input  hazard_pkg::id_req_t    id_req,
    input  hazard_pkg::stage_dst_t ex_dst,
    input  logic                   in_bubble,
    output logic                   load_use
);

    import hazard_pkg::*;

    logic rs1_hit;
    logic rs2_hit;
    logic conflict;
    logic stall_q;

    // ####################################################################
    // address compare against the EX destination.
    // ####################################################################

    assign rs1_hit = src_hits(id_req.rs1, id_req.rs1_used, ex_dst);
    assign rs2_hit = src_hits(id_req.rs2, id_req.rs2_used, ex_dst);

    // only a load in EX cannot be covered by forwarding.
    assign conflict = (rs1_hit || rs2_hit) && ex_dst.is_load;

    // ####################################################################
    // stall memory.
    // ####################################################################

    // last cycle's decision.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= load_use;
        end
    end

    // a conflict already answered by the bubble stays quiet.
    // stall_q alone is not enough, the fsm may have ignored the request.
    always_comb begin
        load_use = conflict;
        if (stall_q && in_bubble) begin
            load_use = 1'b0;
        end
    end

endmodule

// File: source/hazard_pkg.sv
package hazard_pkg;

    import rv_arch_pkg::*;

    // ####################################################################
    // pipeline stage views.
    // ####################################################################

    // destination held by EX, MEM or WB.
    typedef struct packed {
        reg_addr_t rd;
        logic      wr_en;
        logic      is_load;
        xlen_t     data;     // value this stage can forward.
    } stage_dst_t;

    // source operands requested by decode.
    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      rs1_used;
        logic      rs2_used;
        xlen_t     rf_rs1;   // register file read data.
        xlen_t     rf_rs2;
    } id_req_t;

    // ####################################################################
    // control encodings.
    // ####################################################################

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    typedef enum logic [1:0] {
        ST_RUN,
        ST_LOAD_BUBBLE,
        ST_MEM_WAIT
    } stall_state_t;

    typedef struct packed {
        logic stall_id;   // hold PC and IF/ID.
        logic bubble_ex;  // insert nop into EX.
        logic freeze_all; // hold every stage.
        logic mem_fault;  // memory wait timed out.
    } hazard_ctrl_t;

    // true when a later stage writes the register that decode reads.
    function automatic logic src_hits(reg_addr_t rs, logic used, stage_dst_t dst);
        return used && (rs != REG_ZERO) && dst.wr_en && (rs == dst.rd);
    endfunction

endpackage

// File: source/rv_arch_pkg.sv
package rv_arch_pkg;

    // ####################################################################
    // integer datapath widths.
    // ####################################################################

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;

    // one data word of the integer datapath.
    typedef logic [XLEN-1:0] xlen_t;

    // architectural register index, x0 .. x31.
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ####################################################################
    // fixed register indices.
    // ####################################################################

    localparam reg_addr_t REG_ZERO = '0; // x0, reads as zero, writes dropped.

endpackage
